// File: verilog/rv_macros.svh
// Data width, instruction width, reset PC and register count macros
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// Data path and address width
`define RV_XLEN 64

// Instruction word width
`define RV_ILEN 32

// PC loaded on reset
`define RV_RESET_PC 64'h0000_0000_0000_0000

// Integer registers, x0 included
`define RV_NREGS 32

`endif

// File: verilog/rv_pkg.sv
// Opcode, immediate format, ALU op, operand source, FSM state and halt cause types
`default_nettype none

package rv_pkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_IMM    = 7'b0010011,
    OP_STORE  = 7'b0100011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    EXT_I    = 3'b000,
    EXT_U    = 3'b001,
    EXT_S    = 3'b010,
    EXT_B    = 3'b011,
    EXT_J    = 3'b100,
    EXT_NONE = 3'b111
  } ext_op_e;

  typedef enum logic [3:0] {
    ALU_ADD     = 4'b0000,
    ALU_COPYB   = 4'b0011,
    ALU_EBREAK  = 4'b1110,
    ALU_INVALID = 4'b1111
  } alu_op_e;

  typedef enum logic [1:0] {
    BSRC_RS2  = 2'b00,
    BSRC_IMM  = 2'b01,
    BSRC_FOUR = 2'b10
  } alu_bsrc_e;

  typedef enum logic [2:0] {
    ST_FETCH,
    ST_FETCH_REL,
    ST_EXEC,
    ST_STORE,
    ST_STORE_REL,
    ST_HALT
  } ctrl_state_e;

  typedef enum logic [1:0] {
    HALT_NONE    = 2'b00,
    HALT_EBREAK  = 2'b01,
    HALT_ILLEGAL = 2'b10
  } halt_cause_e;

endpackage

`default_nettype wire

// File: verilog/rv_idu.sv
// Instruction decode unit for the seven-instruction RV64I subset
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module rv_idu (
  input  wire [`RV_ILEN-1:0]     i_inst,
  output logic [`RV_XLEN-1:0]    o_imm,
  output logic [4:0]             o_ra,
  output logic [4:0]             o_rb,
  output logic [4:0]             o_rd,
  output logic                   o_wen,
  output logic                   o_asrc_pc,
  output rv_pkg::alu_bsrc_e      o_bsrc,
  output rv_pkg::alu_op_e        o_alu_op,
  output logic                   o_pca_imm,
  output logic                   o_pcb_rs1,
  output logic                   o_is_store
);
  import rv_pkg::*;

  opcode_e             opcode;
  logic [2:0]          funct3;
  ext_op_e             ext_op;
  logic [`RV_XLEN-1:0] imm_i, imm_u, imm_s, imm_j;
  logic                inst_lui, inst_auipc, inst_jal, inst_jalr;
  logic                inst_addi, inst_sd, inst_ebreak;
  logic                type_i, type_u, type_s, type_j;

  assign opcode = opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign o_ra   = i_inst[19:15];
  assign o_rb   = i_inst[24:20];
  assign o_rd   = i_inst[11:7];

  // ############################################################
  // Immediates sign-extended to XLEN
  assign imm_i = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{(`RV_XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_s = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_j = {{(`RV_XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // ############################################################
  // Instruction match
  assign inst_lui    = (opcode == OP_LUI);
  assign inst_auipc  = (opcode == OP_AUIPC);
  assign inst_jal    = (opcode == OP_JAL);
  assign inst_jalr   = (opcode == OP_JALR) && (funct3 == 3'b000);
  assign inst_addi   = (opcode == OP_IMM) && (funct3 == 3'b000);
  assign inst_sd     = (opcode == OP_STORE) && (funct3 == 3'b011);
  assign inst_ebreak = (opcode == OP_SYSTEM) && (funct3 == 3'b000) && (i_inst[31:20] == 12'h001);

  assign type_i = inst_addi | inst_jalr | inst_ebreak;
  assign type_u = inst_lui | inst_auipc;
  assign type_s = inst_sd;
  assign type_j = inst_jal;

  always_comb begin
    if (type_i)      ext_op = EXT_I;
    else if (type_u) ext_op = EXT_U;
    else if (type_s) ext_op = EXT_S;
    else if (type_j) ext_op = EXT_J;
    else             ext_op = EXT_NONE;
  end

  always_comb begin
    case (ext_op)
      EXT_I:   o_imm = imm_i;
      EXT_U:   o_imm = imm_u;
      EXT_S:   o_imm = imm_s;
      EXT_J:   o_imm = imm_j;
      default: o_imm = '0;
    endcase
  end

  // ############################################################
  // Control outputs
  assign o_wen      = type_i | type_u | type_j;
  assign o_asrc_pc  = inst_jal | inst_jalr | inst_auipc; // Link and PC-relative values
  assign o_pca_imm  = type_j | inst_jalr;
  assign o_pcb_rs1  = inst_jalr;
  assign o_is_store = inst_sd;

  always_comb begin
    if (inst_jal || inst_jalr)           o_bsrc = BSRC_FOUR;
    else if (type_i || type_u || type_s) o_bsrc = BSRC_IMM;
    else                                 o_bsrc = BSRC_RS2;
  end

  always_comb begin
    if (inst_lui)         o_alu_op = ALU_COPYB;
    else if (inst_ebreak) o_alu_op = ALU_EBREAK;
    else if (inst_auipc || inst_jal || inst_jalr || inst_addi || inst_sd) o_alu_op = ALU_ADD;
    else                  o_alu_op = ALU_INVALID;
  end

  // Each known word decodes into exactly one format and an unknown word into none
  always_comb begin
    if (!$isunknown(i_inst))
      assert final ($onehot0({type_i, type_u, type_s, type_j}) &&
                    ((o_alu_op == ALU_INVALID) == !(type_i | type_u | type_s | type_j)))
        else $error("rv_idu: format match disagrees with the decoded operation");
  end

endmodule

`default_nettype wire

// File: verilog/rv_alu.sv
// ALU with operand select, add and B copy for the RV64I subset core
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module rv_alu (
  input  wire [`RV_XLEN-1:0]     i_pc,
  input  wire [`RV_XLEN-1:0]     i_rs1_data,
  input  wire [`RV_XLEN-1:0]     i_rs2_data,
  input  wire [`RV_XLEN-1:0]     i_imm,
  input  wire                    i_asrc_pc,
  input  wire rv_pkg::alu_bsrc_e i_bsrc,
  input  wire rv_pkg::alu_op_e   i_alu_op,
  output logic [`RV_XLEN-1:0]    o_result
);
  import rv_pkg::*;

  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;

  assign op_a = i_asrc_pc ? i_pc : i_rs1_data;

  always_comb begin
    case (i_bsrc)
      BSRC_RS2:  op_b = i_rs2_data;
      BSRC_IMM:  op_b = i_imm;
      BSRC_FOUR: op_b = `RV_XLEN'd4;
      default:   op_b = '0;
    endcase
  end

  // Ebreak and unknown ops give zero
  always_comb begin
    case (i_alu_op)
      ALU_ADD:   o_result = op_a + op_b;
      ALU_COPYB: o_result = op_b;
      default:   o_result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/rv_regfile.sv
// Integer register file with two asynchronous read ports and one write port
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module rv_regfile (
  input  wire                 i_clk,
  input  wire                 i_rst,
  input  wire                 i_we,
  input  wire [4:0]           i_ra,
  input  wire [4:0]           i_rb,
  input  wire [4:0]           i_rd,
  input  wire [`RV_XLEN-1:0]  i_wdata,
  output logic [`RV_XLEN-1:0] o_rdata_a,
  output logic [`RV_XLEN-1:0] o_rdata_b
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_rd != 5'd0)) begin // x0 never written
      regs[i_rd] <= i_wdata;
    end
  end

  assign o_rdata_a = regs[i_ra];
  assign o_rdata_b = regs[i_rb];

  // x0 reads back zero on both ports, whatever the core tried to write
  assert property (@(posedge i_clk) disable iff (i_rst)
    ((i_ra == 5'd0) |-> (o_rdata_a == '0)) and ((i_rb == 5'd0) |-> (o_rdata_b == '0)))
    else $error("rv_regfile: x0 read as nonzero");

endmodule

`default_nettype wire

// File: verilog/rv_pc_unit.sv
// Program counter register with next-PC adder
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module rv_pc_unit (
  input  wire                 i_clk,
  input  wire                 i_rst,
  input  wire                 i_step,
  input  wire                 i_pca_imm,
  input  wire                 i_pcb_rs1,
  input  wire [`RV_XLEN-1:0]  i_imm,
  input  wire [`RV_XLEN-1:0]  i_rs1_data,
  output logic [`RV_XLEN-1:0] o_pc
);

  logic [`RV_XLEN-1:0] pc_a;
  logic [`RV_XLEN-1:0] pc_b;
  logic [`RV_XLEN-1:0] pc_sum;
  logic [`RV_XLEN-1:0] pc_next;

  assign pc_a    = i_pca_imm ? i_imm : `RV_XLEN'd4;
  assign pc_b    = i_pcb_rs1 ? i_rs1_data : o_pc;
  assign pc_sum  = pc_a + pc_b;
  assign pc_next = i_pcb_rs1 ? {pc_sum[`RV_XLEN-1:1], 1'b0} : pc_sum; // jalr target

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_pc <= `RV_RESET_PC;
    end else if (i_step) begin
      o_pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

// File: verilog/rv_ctrl_fsm.sv
// Control FSM with memory handshake, instruction register and execute strobes
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module rv_ctrl_fsm (
  input  wire                  i_clk,
  input  wire                  i_rst,
  input  wire                  i_mem_ack,
  input  wire [`RV_ILEN-1:0]   i_mem_rdata,
  input  wire [`RV_XLEN-1:0]   i_pc,
  input  wire [`RV_XLEN-1:0]   i_alu_result,
  input  wire [`RV_XLEN-1:0]   i_rs2_data,
  input  wire                  i_is_store,
  input  wire rv_pkg::alu_op_e i_alu_op,
  output logic                 o_mem_req,
  output logic                 o_mem_we,
  output logic [`RV_XLEN-1:0]  o_mem_addr,
  output logic [`RV_XLEN-1:0]  o_mem_wdata,
  output logic [`RV_ILEN-1:0]  o_inst,
  output logic                 o_reg_wr_strobe,
  output logic                 o_pc_step,
  output logic                 o_halted,
  output rv_pkg::halt_cause_e  o_halt_cause
);
  import rv_pkg::*;

  localparam logic [`RV_ILEN-1:0] NOP_INST = 32'h0000_0013; // addi x0, x0, 0

  ctrl_state_e state;
  logic        halt_op;

  assign halt_op = (i_alu_op == ALU_EBREAK) || (i_alu_op == ALU_INVALID);

  // ############################################################
  // Execute strobes
  assign o_reg_wr_strobe = (state == ST_EXEC) && !halt_op;
  assign o_pc_step = ((state == ST_EXEC) && !halt_op && !i_is_store) ||
                     ((state == ST_STORE_REL) && !i_mem_ack); // PC moves once the store is done

  // ############################################################
  // State and handshake
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state        <= ST_FETCH;
      o_mem_req    <= 1'b0;
      o_mem_we     <= 1'b0;
      o_inst       <= NOP_INST;
      o_halted     <= 1'b0;
      o_halt_cause <= HALT_NONE;
    end else begin
      case (state)
        ST_FETCH: begin
          if (!o_mem_req && !i_mem_ack) begin
            o_mem_req <= 1'b1;
            o_mem_we  <= 1'b0;
          end else if (o_mem_req && i_mem_ack) begin
            o_mem_req <= 1'b0;
            o_inst    <= i_mem_rdata;
            state     <= ST_FETCH_REL;
          end
        end
        ST_FETCH_REL: if (!i_mem_ack) state <= ST_EXEC;
        ST_EXEC: begin
          if (i_alu_op == ALU_EBREAK) begin
            o_halted     <= 1'b1;
            o_halt_cause <= HALT_EBREAK;
            state        <= ST_HALT;
          end else if (i_alu_op == ALU_INVALID) begin
            o_halted     <= 1'b1;
            o_halt_cause <= HALT_ILLEGAL;
            state        <= ST_HALT;
          end else if (i_is_store) begin
            state <= ST_STORE;
          end else begin
            state <= ST_FETCH;
          end
        end
        ST_STORE: begin
          if (!o_mem_req && !i_mem_ack) begin
            o_mem_req <= 1'b1;
            o_mem_we  <= 1'b1;
          end else if (o_mem_req && i_mem_ack) begin
            o_mem_req <= 1'b0;
            o_mem_we  <= 1'b0;
            state     <= ST_STORE_REL;
          end
        end
        ST_STORE_REL: if (!i_mem_ack) state <= ST_FETCH;
        ST_HALT:      state <= ST_HALT;                 // Only reset leaves
        default:      state <= ST_HALT;
      endcase
    end
  end

  // Address mux with the PC for fetch and the ALU result for store
  always_ff @(posedge i_clk) begin
    if ((state == ST_FETCH) && !o_mem_req) begin
      o_mem_addr <= i_pc;
    end else if ((state == ST_EXEC) && i_is_store) begin
      o_mem_addr  <= i_alu_result;
      o_mem_wdata <= i_rs2_data;
    end
  end

  // Request is withdrawn only after memory has answered
  assert property (@(posedge i_clk) disable iff (i_rst) $fell(o_mem_req) |-> $past(i_mem_ack))
    else $error("rv_ctrl_fsm: req dropped before ack");

  // New request never overlaps the previous ack
  assert property (@(posedge i_clk) disable iff (i_rst)
    $rose(o_mem_req) |-> !$past(i_mem_ack))
    else $error("rv_ctrl_fsm: req raised while ack high");

endmodule

`default_nettype wire

// File: verilog/rv_core.sv
// Top level of the multicycle RV64I subset core with one memory port
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module rv_core (
  input  wire                  i_clk,
  input  wire                  i_rst,
  output logic                 o_mem_req,
  output logic                 o_mem_we,
  output logic [`RV_XLEN-1:0]  o_mem_addr,
  output logic [`RV_XLEN-1:0]  o_mem_wdata,
  input  wire                  i_mem_ack,
  input  wire [`RV_ILEN-1:0]   i_mem_rdata,
  output logic                 o_halted,
  output rv_pkg::halt_cause_e  o_halt_cause
);
  import rv_pkg::*;

  logic [`RV_ILEN-1:0] inst;
  logic [`RV_XLEN-1:0] imm;
  logic [4:0]          ra;
  logic [4:0]          rb;
  logic [4:0]          rd;
  logic                wen;
  logic                asrc_pc;
  alu_bsrc_e           bsrc;
  alu_op_e             alu_op;
  logic                pca_imm;
  logic                pcb_rs1;
  logic                is_store;
  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic [`RV_XLEN-1:0] alu_result;
  logic                reg_wr_strobe;
  logic                pc_step;

  rv_ctrl_fsm u_fsm (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_mem_ack       (i_mem_ack),
    .i_mem_rdata     (i_mem_rdata),
    .i_pc            (pc),
    .i_alu_result    (alu_result),
    .i_rs2_data      (rs2_data),
    .i_is_store      (is_store),
    .i_alu_op        (alu_op),
    .o_mem_req       (o_mem_req),
    .o_mem_we        (o_mem_we),
    .o_mem_addr      (o_mem_addr),
    .o_mem_wdata     (o_mem_wdata),
    .o_inst          (inst),
    .o_reg_wr_strobe (reg_wr_strobe),
    .o_pc_step       (pc_step),
    .o_halted        (o_halted),
    .o_halt_cause    (o_halt_cause)
  );

  rv_pc_unit u_pc (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_step     (pc_step),
    .i_pca_imm  (pca_imm),
    .i_pcb_rs1  (pcb_rs1),
    .i_imm      (imm),
    .i_rs1_data (rs1_data),
    .o_pc       (pc)
  );

  rv_idu u_idu (
    .i_inst     (inst),
    .o_imm      (imm),
    .o_ra       (ra),
    .o_rb       (rb),
    .o_rd       (rd),
    .o_wen      (wen),
    .o_asrc_pc  (asrc_pc),
    .o_bsrc     (bsrc),
    .o_alu_op   (alu_op),
    .o_pca_imm  (pca_imm),
    .o_pcb_rs1  (pcb_rs1),
    .o_is_store (is_store)
  );

  rv_alu u_alu (
    .i_pc       (pc),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .i_imm      (imm),
    .i_asrc_pc  (asrc_pc),
    .i_bsrc     (bsrc),
    .i_alu_op   (alu_op),
    .o_result   (alu_result)
  );

  // Write needs both the execute strobe and the decoded enable
  rv_regfile u_rf (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_we      (reg_wr_strobe & wen),
    .i_ra      (ra),
    .i_rb      (rb),
    .i_rd      (rd),
    .i_wdata   (alu_result),
    .o_rdata_a (rs1_data),
    .o_rdata_b (rs2_data)
  );

endmodule

`default_nettype wire

// File: test/rv_core_tb.sv
// Testbench for the RV64I subset core with memory model, reference model and store checks
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module rv_core_tb;
  import rv_pkg::*;

  localparam int MEM_WORDS = 64;
  localparam int MAX_STEPS = 200;
  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;
  localparam logic [31:0] ADD_WORD = {7'b0, 5'd1, 5'd1, 3'b000, 5'd2, 7'b0110011}; // add x2,x1,x1

  logic                clk = 1'b0;
  logic                i_rst = 1'b1;
  logic                i_mem_ack = 1'b0;
  logic [`RV_ILEN-1:0] i_mem_rdata = '0;
  logic                o_mem_req;
  logic                o_mem_we;
  logic [`RV_XLEN-1:0] o_mem_addr;
  logic [`RV_XLEN-1:0] o_mem_wdata;
  logic                o_halted;
  halt_cause_e         o_halt_cause;

  logic [`RV_ILEN-1:0] mem [MEM_WORDS];
  int                  prog_len = 0;
  logic [`RV_XLEN-1:0] exp_addr_q [$];
  logic [`RV_XLEN-1:0] exp_data_q [$];
  halt_cause_e         exp_halt = HALT_NONE;
  string               test_name = "none";
  int                  errors = 0;
  int                  checks = 0;
  int                  seed = 13617;
  int                  cycle = 0;
  int                  test_start = 0;
  int                  test_limit = 0;
  logic                test_active = 1'b0;
  logic                mem_busy = 1'b0;
  int                  mem_wait = 0;
  logic                store_q = 1'b0;
  logic                halted_q = 1'b0;

  always #4 clk = ~clk;

  rv_core dut0 (
    .i_clk        (clk),
    .i_rst        (i_rst),
    .o_mem_req    (o_mem_req),
    .o_mem_we     (o_mem_we),
    .o_mem_addr   (o_mem_addr),
    .o_mem_wdata  (o_mem_wdata),
    .i_mem_ack    (i_mem_ack),
    .i_mem_rdata  (i_mem_rdata),
    .o_halted     (o_halted),
    .o_halt_cause (o_halt_cause)
  );

  // ##########################################################
  // Instruction encoders
  function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] auipc_word(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0010111};
  endfunction

  function automatic logic [31:0] jal_word(input logic [4:0] rd, input int off);
    logic [20:0] o;
    o = off[20:0];
    return {o[20], o[10:1], o[11], o[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] jalr_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input int imm);
    logic [11:0] i;
    i = imm[11:0];
    return {i, rs1, 3'b000, rd, 7'b1100111};
  endfunction

  function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input int imm);
    logic [11:0] i;
    i = imm[11:0];
    return {i, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] sd_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                          input int off);
    logic [11:0] o;
    o = off[11:0];
    return {o[11:5], rs2, rs1, 3'b011, o[4:0], 7'b0100011};
  endfunction

  // Unmapped space reads as an R-type word, which the core rejects
  function automatic logic [31:0] mem_word(input logic [`RV_XLEN-1:0] addr);
    if (addr[`RV_XLEN-1:8] == '0) return mem[addr[7:2]];
    return {addr[26:2], 7'b0110011};
  endfunction

  task automatic clear_program();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'h0000_0033 | (32'(i) << 7);
    end
    prog_len = 0;
  endtask

  task automatic emit(input logic [31:0] word);
    mem[prog_len] = word;
    prog_len++;
  endtask

  // ##########################################################
  // Reference model that fills the expected store queues
  function automatic halt_cause_e run_reference();
    logic [`RV_XLEN-1:0] x [32];
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] res;
    logic [31:0]         w;
    logic [4:0]          rd, rs1, rs2;
    logic                wr;
    exp_addr_q.delete();
    exp_data_q.delete();
    for (int i = 0; i < 32; i++) begin
      x[i] = '0;
    end
    pc = `RV_RESET_PC;
    for (int step = 0; step < MAX_STEPS; step++) begin
      w   = mem_word(pc);
      rd  = w[11:7];
      rs1 = w[19:15];
      rs2 = w[24:20];
      wr  = 1'b1;
      if (w == EBREAK_WORD) begin
        return HALT_EBREAK;
      end else if (w[6:0] == 7'b0110111) begin                          // lui
        res = {{32{w[31]}}, w[31:12], 12'b0};
        pc  = pc + 4;
      end else if (w[6:0] == 7'b0010111) begin                          // auipc
        res = pc + {{32{w[31]}}, w[31:12], 12'b0};
        pc  = pc + 4;
      end else if (w[6:0] == 7'b1101111) begin                          // jal
        imm = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        res = pc + 4;
        pc  = pc + imm;
      end else if (w[6:0] == 7'b1100111 && w[14:12] == 3'b000) begin    // jalr
        imm = {{52{w[31]}}, w[31:20]};
        res = pc + 4;
        pc  = (x[rs1] + imm) & ~64'd1;
      end else if (w[6:0] == 7'b0010011 && w[14:12] == 3'b000) begin    // addi
        res = x[rs1] + {{52{w[31]}}, w[31:20]};
        pc  = pc + 4;
      end else if (w[6:0] == 7'b0100011 && w[14:12] == 3'b011) begin    // sd
        wr = 1'b0;
        exp_addr_q.push_back(x[rs1] + {{52{w[31]}}, w[31:25], w[11:7]});
        exp_data_q.push_back(x[rs2]);
        pc = pc + 4;
      end else begin
        return HALT_ILLEGAL;
      end
      if (wr && rd != 5'd0) x[rd] = res;
    end
    return HALT_NONE;
  endfunction

  // ##########################################################
  // Compare tasks
  task automatic check_store(input string name, input logic [`RV_XLEN-1:0] exp_addr,
                             input logic [`RV_XLEN-1:0] exp_data,
                             input logic [`RV_XLEN-1:0] act_addr,
                             input logic [`RV_XLEN-1:0] act_data);
    checks++;
    if (act_addr !== exp_addr || act_data !== exp_data) begin
      errors++;
      $display("FAIL %s store: expected [%h] = %h, actual [%h] = %h",
               name, exp_addr, exp_data, act_addr, act_data);
    end
  endtask

  task automatic check_halt(input string name, input halt_cause_e exp_cause,
                            input halt_cause_e act_cause);
    checks++;
    if (act_cause !== exp_cause) begin
      errors++;
      $display("FAIL %s halt cause: expected %s, actual %s (%0d)",
               name, exp_cause.name(), act_cause.name(), act_cause);
    end
  endtask

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  endtask

  // Memory model that acks after a random delay
  always @(posedge clk) begin
    if (i_rst) begin
      i_mem_ack <= 1'b0;
      mem_busy  <= 1'b0;
    end else if (i_mem_ack) begin
      if (!o_mem_req) i_mem_ack <= 1'b0;
    end else if (mem_busy) begin
      if (mem_wait == 0) begin
        i_mem_ack   <= 1'b1;
        i_mem_rdata <= mem_word(o_mem_addr);
        mem_busy    <= 1'b0;
      end else begin
        mem_wait <= mem_wait - 1;
      end
    end else if (o_mem_req) begin
      mem_busy <= 1'b1;
      mem_wait <= $unsigned($random(seed)) % 6;
    end
  end

  always @(posedge clk) begin : compare_results
    logic [`RV_XLEN-1:0] ea;
    logic [`RV_XLEN-1:0] ed;
    if (i_rst) begin
      store_q  <= 1'b0;
      halted_q <= 1'b0;
    end else begin
      store_q  <= o_mem_req && o_mem_we;
      halted_q <= o_halted;
      if (o_mem_req && o_mem_we && !store_q) begin
        if (exp_addr_q.size() == 0) begin
          errors++;
          $display("Unexpected store in %s to address %h", test_name, o_mem_addr);
        end else begin
          ea = exp_addr_q.pop_front();
          ed = exp_data_q.pop_front();
          check_store(test_name, ea, ed, o_mem_addr, o_mem_wdata);
        end
      end
      if (o_halted && !halted_q) begin
        check_halt(test_name, exp_halt, o_halt_cause);
        if (exp_addr_q.size() != 0) begin
          errors++;
          $display("%s halted with %0d expected stores missing", test_name, exp_addr_q.size());
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (test_active && (cycle - test_start > test_limit)) begin
      errors++;
      $display("Timeout in %s: core did not halt within %0d cycles", test_name, test_limit);
      finish_run();
    end
  end

  task automatic run_test(input string name);
    test_name  = name;
    exp_halt   = run_reference();
    test_limit = prog_len * 2 * (5 + 3) + 50;
    @(posedge clk);
    i_rst <= 1'b1;
    repeat (4) @(posedge clk);
    i_rst <= 1'b0;
    test_start  = cycle;
    test_active = 1'b1;
    while (!o_halted) @(posedge clk);
    repeat (10) @(posedge clk);                      // Room for stray stores after halt
    test_active = 1'b0;
  endtask

  initial begin
    clear_program();
    emit(lui_word(5'd1, 20'h12345));
    emit(addi_word(5'd1, 5'd1, 'h678));
    emit(addi_word(5'd2, 5'd0, -5));
    emit(lui_word(5'd3, 20'h00001));
    emit(sd_word(5'd1, 5'd3, 8));
    emit(sd_word(5'd2, 5'd3, -8));
    emit(lui_word(5'd4, 20'h80000));
    emit(addi_word(5'd4, 5'd4, -1));
    emit(sd_word(5'd4, 5'd3, 16));
    emit(EBREAK_WORD);
    run_test("store_values");

    clear_program();
    emit(lui_word(5'd3, 20'h00001));
    emit(auipc_word(5'd5, 20'h00002));
    emit(jal_word(5'd6, 12));
    emit(sd_word(5'd5, 5'd3, 0));                    // Skipped by the jump
    emit(sd_word(5'd6, 5'd3, 0));
    emit(sd_word(5'd5, 5'd3, 8));
    emit(sd_word(5'd6, 5'd3, 16));
    emit(EBREAK_WORD);
    run_test("auipc_jal");

    clear_program();
    emit(lui_word(5'd3, 20'h00001));
    emit(addi_word(5'd7, 5'd0, 17));
    emit(jalr_word(5'd8, 5'd7, 4));                  // 21 rounds down to 20
    emit(sd_word(5'd8, 5'd3, 0));
    emit(EBREAK_WORD);
    emit(auipc_word(5'd10, 20'h00000));              // Captures the jump target
    emit(sd_word(5'd8, 5'd3, 8));
    emit(sd_word(5'd10, 5'd3, 16));
    emit(EBREAK_WORD);
    run_test("jalr_link");

    clear_program();
    emit(addi_word(5'd0, 5'd0, 123));
    emit(lui_word(5'd3, 20'h00001));
    emit(sd_word(5'd0, 5'd3, 24));
    emit(addi_word(5'd9, 5'd0, -1));
    emit(sd_word(5'd9, 5'd3, 32));
    emit(EBREAK_WORD);
    run_test("x0_zero");

    clear_program();
    emit(addi_word(5'd1, 5'd0, 7));
    emit(lui_word(5'd3, 20'h00001));
    emit(sd_word(5'd1, 5'd3, 0));
    emit(EBREAK_WORD);
    emit(sd_word(5'd1, 5'd3, 8));
    emit(EBREAK_WORD);
    run_test("ebreak_halt");

    clear_program();
    emit(addi_word(5'd1, 5'd0, 42));
    emit(lui_word(5'd3, 20'h00001));
    emit(sd_word(5'd1, 5'd3, 0));
    emit(ADD_WORD);
    emit(sd_word(5'd2, 5'd3, 8));
    emit(EBREAK_WORD);
    run_test("illegal_halt");

    finish_run();
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_idu.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_pc_unit.sv
verilog/rv_ctrl_fsm.sv
verilog/rv_core.sv
test/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_pkg.sv
      - verilog/rv_idu.sv
      - verilog/rv_alu.sv
      - verilog/rv_regfile.sv
      - verilog/rv_pc_unit.sv
      - verilog/rv_ctrl_fsm.sv
      - verilog/rv_core.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/rv_core_tb.sv
